// ==== design/gat_softmax_pkg.sv ====
package gat_softmax_pkg;

  // ======================================================================
  // widths
  // ======================================================================
  localparam int COEF_W      = 5;
  localparam int EXP_W       = 32;
  localparam int SUM_W       = 40;
  localparam int NODE_W      = 4;
  localparam int GRAPH_W     = 6;

  // alpha format, Q1.15
  localparam int ALPHA_WOI   = 1;
  localparam int ALPHA_WOF   = 15;
  localparam int ALPHA_W     = ALPHA_WOI + ALPHA_WOF;

  // input reg + one stage per quotient bit + saturation reg
  localparam int DIV_LATENCY = ALPHA_W + 2;

  typedef logic [COEF_W-1:0]  coef_t;
  typedef logic [EXP_W-1:0]   exp_t;
  typedef logic [SUM_W-1:0]   sum_t;
  typedef logic [NODE_W-1:0]  node_cnt_t;
  typedef logic [GRAPH_W-1:0] graph_idx_t;
  typedef logic [ALPHA_W-1:0] alpha_t;

  // one entry per subgraph, sum stage to divide stage
  typedef struct packed {
    node_cnt_t num_node;
    sum_t      sum;
  } dvsr_entry_t;

  typedef struct packed {
    alpha_t alpha;
    logic   last;
  } alpha_word_t;

endpackage

// ==== design/sync_fifo.sv ====
`timescale 1ns/10ps

module sync_fifo #(
  parameter int DATA_W = 8,
  parameter int DEPTH  = 16
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [DATA_W-1:0]          din,
  input  logic                       wr,
  output logic                       full,
  output logic [DATA_W-1:0]          dout,
  input  logic                       rd,
  output logic                       empty,
  output logic [$clog2(DEPTH+1)-1:0] count
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [DATA_W-1:0] mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic              do_wr;
  logic              do_rd;

  assign do_wr = wr && !full;
  assign do_rd = rd && !empty;
  assign full  = (count == DEPTH);
  assign empty = (count == '0);

  // show-ahead, head is always visible
  assign dout = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) wr |-> !full);
  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) rd |-> !empty);

endmodule

// ==== design/coef_ingress.sv ====
`timescale 1ns/10ps

module coef_ingress
  import gat_softmax_pkg::*;
#(
  parameter int COEF_DEPTH = 16,
  parameter int MAX_GRAPHS = 64
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       cfg_wr,
  input  graph_idx_t cfg_addr,
  input  node_cnt_t  cfg_num_node,
  input  logic       coef_wr,
  input  coef_t      coef,
  output logic       coef_full,
  input  logic       coef_pop,
  output coef_t      coef_head,
  output logic       coef_empty,
  input  graph_idx_t graph_addr,
  output node_cnt_t  num_node
);

  // node count per subgraph
  node_cnt_t node_tbl [MAX_GRAPHS];

  sync_fifo #(
    .DATA_W (COEF_W),
    .DEPTH  (COEF_DEPTH)
  ) u_coef_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .din   (coef),
    .wr    (coef_wr),
    .full  (coef_full),
    .dout  (coef_head),
    .rd    (coef_pop),
    .empty (coef_empty),
    .count ()
  );

  always_ff @(posedge clk) begin
    if (cfg_wr) begin
      node_tbl[cfg_addr] <= cfg_num_node;
    end
  end

  // registered table read, one cycle behind graph_addr
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      num_node <= '0;
    end else begin
      num_node <= node_tbl[graph_addr];
    end
  end

  a_nonzero_cfg: assert property (@(posedge clk) disable iff (!rst_n)
    cfg_wr |-> (cfg_num_node != '0));

endmodule

// ==== design/softmax_unit.sv ====
`timescale 1ns/10ps

module softmax_unit
  import gat_softmax_pkg::*;
#(
  parameter int QUEUE_DEPTH = 32
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       sm_en,
  input  coef_t      coef_head,
  input  logic       coef_empty,
  output logic       coef_pop,
  output graph_idx_t graph_addr,
  input  node_cnt_t  num_node,
  input  logic       egress_stall,
  output logic       div_vld,
  output exp_t       dividend,
  output sum_t       divisor,
  output logic       div_last
);

  // sum side
  node_cnt_t   sum_cnt;
  sum_t        sum_q;
  sum_t        sum_next;
  exp_t        exp_val;
  logic        sum_last;
  logic        addr_settle;

  // queues between the two sides
  logic        divd_full;
  logic        divd_empty;
  exp_t        divd_head;
  logic        dvsr_full;
  logic        dvsr_empty;
  logic        dvsr_pop;
  dvsr_entry_t dvsr_in;
  dvsr_entry_t dvsr_head;

  // divide side
  node_cnt_t   div_cnt;
  node_cnt_t   div_num;
  node_cnt_t   cur_num;
  sum_t        cur_sum;
  logic        div_first;

  sync_fifo #(
    .DATA_W (EXP_W),
    .DEPTH  (QUEUE_DEPTH)
  ) u_divd_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .din   (exp_val),
    .wr    (coef_pop),
    .full  (divd_full),
    .dout  (divd_head),
    .rd    (div_vld),
    .empty (divd_empty),
    .count ()
  );

  sync_fifo #(
    .DATA_W ($bits(dvsr_entry_t)),
    .DEPTH  (QUEUE_DEPTH)
  ) u_dvsr_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .din   (dvsr_in),
    .wr    (coef_pop && sum_last),
    .full  (dvsr_full),
    .dout  (dvsr_head),
    .rd    (dvsr_pop),
    .empty (dvsr_empty),
    .count ()
  );

  // ======================================================================
  // exponent and running sum
  // ======================================================================
  // wait one cycle after an address change so num_node catches up
  assign coef_pop = sm_en && !coef_empty && !divd_full && !dvsr_full && !addr_settle;
  assign exp_val  = exp_t'(1) << coef_head;
  assign sum_last = (sum_cnt == num_node - 1'b1);
  assign sum_next = (sum_cnt == '0) ? sum_t'(exp_val) : sum_q + sum_t'(exp_val);
  assign dvsr_in  = '{num_node: num_node, sum: sum_next};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum_cnt     <= '0;
      graph_addr  <= '0;
      addr_settle <= 1'b1;
    end else begin
      addr_settle <= 1'b0;
      if (coef_pop) begin
        if (sum_last) begin
          sum_cnt     <= '0;
          graph_addr  <= graph_addr + 1'b1;
          addr_settle <= 1'b1;
        end else begin
          sum_cnt <= sum_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (coef_pop) begin
      sum_q <= sum_next;
    end
  end

  // ======================================================================
  // division issue
  // ======================================================================
  // first node of a subgraph takes the divisor straight from the queue head
  assign div_first = (div_cnt == '0);
  assign div_num   = div_first ? dvsr_head.num_node : cur_num;
  assign divisor   = div_first ? dvsr_head.sum : cur_sum;
  assign dividend  = divd_head;
  assign div_vld   = !divd_empty && !egress_stall && (!div_first || !dvsr_empty);
  assign div_last  = div_vld && (div_cnt == div_num - 1'b1);
  assign dvsr_pop  = div_vld && div_first;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt <= '0;
    end else if (div_vld) begin
      div_cnt <= div_last ? '0 : div_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (dvsr_pop) begin
      cur_num <= dvsr_head.num_node;
      cur_sum <= dvsr_head.sum;
    end
  end

  a_nonzero_dvsr: assert property (@(posedge clk) disable iff (!rst_n)
    div_vld |-> (divisor != '0));

endmodule

// ==== design/fxp_div_pipe.sv ====
`timescale 1ns/10ps

module fxp_div_pipe
  import gat_softmax_pkg::*;
#(
  parameter int WOI = 1,
  parameter int WOF = 15
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               div_vld,
  input  exp_t               dividend,
  input  sum_t               divisor,
  output logic               div_done,
  output logic [WOI+WOF-1:0] quotient
);

  localparam int QW  = WOI + WOF;
  // wide enough for the divisor shifted by the top quotient bit
  localparam int RW  = SUM_W + QW;
  localparam logic [QW-1:0] ONE = QW'(1) << WOF;

  logic [RW-1:0] rem_q  [QW+1];
  sum_t          dvsr_q [QW+1];
  logic [QW-1:0] quo_q  [QW+1];
  logic [QW:0]   vld_q;

  // valid bit travels beside the data
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q    <= '0;
      div_done <= 1'b0;
    end else begin
      vld_q    <= {vld_q[QW-1:0], div_vld};
      div_done <= vld_q[QW];
    end
  end

  // ======================================================================
  // restoring stages, msb first
  // ======================================================================
  always_ff @(posedge clk) begin
    // prescale by 2^WOF
    rem_q[0]  <= RW'(dividend) << WOF;
    dvsr_q[0] <= divisor;
    quo_q[0]  <= '0;
    for (int k = 1; k <= QW; k++) begin
      dvsr_q[k] <= dvsr_q[k-1];
      if (rem_q[k-1] >= (RW'(dvsr_q[k-1]) << (QW - k))) begin
        rem_q[k] <= rem_q[k-1] - (RW'(dvsr_q[k-1]) << (QW - k));
        quo_q[k] <= quo_q[k-1] | (QW'(1) << (QW - k));
      end else begin
        rem_q[k] <= rem_q[k-1];
        quo_q[k] <= quo_q[k-1];
      end
    end
    // exactly 1.0 only for a single-node subgraph
    quotient <= (quo_q[QW] == ONE) ? '1 : quo_q[QW];
  end

endmodule

// ==== design/alpha_egress.sv ====
`timescale 1ns/10ps

module alpha_egress
  import gat_softmax_pkg::*;
#(
  parameter int ALPHA_DEPTH = 32
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        div_done,
  input  alpha_t      quotient,
  input  logic        div_last,
  output logic        egress_stall,
  input  logic        out_rd,
  output alpha_word_t out_word,
  output logic        out_empty
);

  localparam int CNT_W = $clog2(ALPHA_DEPTH + 1);

  logic [DIV_LATENCY-1:0] last_line;
  alpha_word_t            wr_word;
  logic                   alpha_full;
  logic [CNT_W-1:0]       alpha_count;

  // last flag delayed to meet its quotient
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      last_line <= '0;
    end else begin
      last_line <= {last_line[DIV_LATENCY-2:0], div_last};
    end
  end

  assign wr_word = '{alpha: quotient, last: last_line[DIV_LATENCY-1]};

  sync_fifo #(
    .DATA_W ($bits(alpha_word_t)),
    .DEPTH  (ALPHA_DEPTH)
  ) u_alpha_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .din   (wr_word),
    .wr    (div_done),
    .full  (alpha_full),
    .dout  (out_word),
    .rd    (out_rd),
    .empty (out_empty),
    .count (alpha_count)
  );

  // room for everything in flight plus one cycle of stall delay
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      egress_stall <= 1'b0;
    end else begin
      egress_stall <= (ALPHA_DEPTH - int'(alpha_count)) < (DIV_LATENCY + 2);
    end
  end

  a_no_drop: assert property (@(posedge clk) disable iff (!rst_n)
    div_done |-> !alpha_full);

endmodule

// ==== design/gat_softmax_top.sv ====
`timescale 1ns/10ps

module gat_softmax_top
  import gat_softmax_pkg::*;
#(
  parameter int COEF_DEPTH  = 16,
  parameter int QUEUE_DEPTH = 32,
  parameter int ALPHA_DEPTH = 32,
  parameter int MAX_GRAPHS  = 64
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        cfg_wr,
  input  graph_idx_t  cfg_addr,
  input  node_cnt_t   cfg_num_node,
  input  logic        coef_wr,
  input  coef_t       coef,
  output logic        coef_full,
  input  logic        sm_en,
  input  logic        out_rd,
  output alpha_word_t out_word,
  output logic        out_empty
);

  // ingress to softmax
  coef_t      coef_head;
  logic       coef_empty;
  logic       coef_pop;
  graph_idx_t graph_addr;
  node_cnt_t  num_node;

  // softmax to divider and egress
  logic       div_vld;
  exp_t       dividend;
  sum_t       divisor;
  logic       div_last;
  logic       egress_stall;

  // divider to egress
  logic       div_done;
  alpha_t     quotient;

  coef_ingress #(
    .COEF_DEPTH (COEF_DEPTH),
    .MAX_GRAPHS (MAX_GRAPHS)
  ) u_ingress (
    .clk          (clk),
    .rst_n        (rst_n),
    .cfg_wr       (cfg_wr),
    .cfg_addr     (cfg_addr),
    .cfg_num_node (cfg_num_node),
    .coef_wr      (coef_wr),
    .coef         (coef),
    .coef_full    (coef_full),
    .coef_pop     (coef_pop),
    .coef_head    (coef_head),
    .coef_empty   (coef_empty),
    .graph_addr   (graph_addr),
    .num_node     (num_node)
  );

  softmax_unit #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_softmax (
    .clk          (clk),
    .rst_n        (rst_n),
    .sm_en        (sm_en),
    .coef_head    (coef_head),
    .coef_empty   (coef_empty),
    .coef_pop     (coef_pop),
    .graph_addr   (graph_addr),
    .num_node     (num_node),
    .egress_stall (egress_stall),
    .div_vld      (div_vld),
    .dividend     (dividend),
    .divisor      (divisor),
    .div_last     (div_last)
  );

  fxp_div_pipe #(
    .WOI (ALPHA_WOI),
    .WOF (ALPHA_WOF)
  ) u_div (
    .clk      (clk),
    .rst_n    (rst_n),
    .div_vld  (div_vld),
    .dividend (dividend),
    .divisor  (divisor),
    .div_done (div_done),
    .quotient (quotient)
  );

  alpha_egress #(
    .ALPHA_DEPTH (ALPHA_DEPTH)
  ) u_egress (
    .clk          (clk),
    .rst_n        (rst_n),
    .div_done     (div_done),
    .quotient     (quotient),
    .div_last     (div_last),
    .egress_stall (egress_stall),
    .out_rd       (out_rd),
    .out_word     (out_word),
    .out_empty    (out_empty)
  );

endmodule

// ==== verif/gat_softmax_tb.sv ====
`timescale 1ns/10ps

module gat_softmax_tb
  import gat_softmax_pkg::*;
();

  localparam int NUM_GRAPHS     = 40;
  localparam int MAX_NODES      = 15;
  localparam int MAX_COEF       = 20;
  localparam int TIMEOUT_CYCLES = NUM_GRAPHS * MAX_NODES * MAX_COEF + 2000;
  localparam int COEF_DEPTH     = 16;
  localparam int ALPHA_DEPTH    = 32;
  localparam int EQUAL_GRAPH    = 5;
  localparam bit [31:0] SEED    = 32'h240bff2f;

  logic        clk;
  logic        rst_n;
  logic        cfg_wr;
  graph_idx_t  cfg_addr;
  node_cnt_t   cfg_num_node;
  logic        coef_wr;
  coef_t       coef;
  logic        coef_full;
  logic        sm_en;
  logic        out_rd;
  alpha_word_t out_word;
  logic        out_empty;

  // expected words in output order
  alpha_word_t exp_q [$];
  int          n_expected;
  int          n_checked;
  int          n_written;
  int          cycle_cnt = 0;

  gat_softmax_top #(
    .COEF_DEPTH  (COEF_DEPTH),
    .QUEUE_DEPTH (32),
    .ALPHA_DEPTH (ALPHA_DEPTH),
    .MAX_GRAPHS  (64)
  ) DUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .cfg_wr       (cfg_wr),
    .cfg_addr     (cfg_addr),
    .cfg_num_node (cfg_num_node),
    .coef_wr      (coef_wr),
    .coef         (coef),
    .coef_full    (coef_full),
    .sm_en        (sm_en),
    .out_rd       (out_rd),
    .out_word     (out_word),
    .out_empty    (out_empty)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("test failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_alpha(input alpha_t got, input alpha_t exp, input int idx);
    if (got !== exp) begin
      abort_run($sformatf("CHECK FAILED at %0t: alpha of word %0d is %h, expected %h",
                          $time, idx, got, exp));
    end
  endtask

  task automatic check_last(input logic got, input logic exp, input int idx);
    if (got !== exp) begin
      abort_run($sformatf("CHECK FAILED at %0t: last flag of word %0d is %b, expected %b",
                          $time, idx, got, exp));
    end
  endtask

  // full may only show once a whole FIFO of coefficients is still unread
  task automatic check_coef_full(input logic got, input int outstanding);
    if (got && outstanding < COEF_DEPTH) begin
      abort_run($sformatf("CHECK FAILED at %0t: coef_full high with %0d coefficients unread",
                          $time, outstanding));
    end
  endtask

  // floor(2^e * 2^15 / sum), 1.0 saturates to all ones
  function automatic alpha_t ref_alpha(input coef_t coefs [MAX_NODES], input int n,
                                       input int idx);
    logic [63:0] sum;
    logic [63:0] quo;
    sum = 64'd0;
    for (int i = 0; i < n; i++) begin
      sum = sum + (64'd1 << coefs[i]);
    end
    quo = ((64'd1 << coefs[idx]) << ALPHA_WOF) / sum;
    if (quo >= 64'd32768) begin
      return '1;
    end
    return alpha_t'(quo);
  endfunction

  // ======================================================================
  // stimulus: table load, then coefficient stream
  // ======================================================================
  initial begin
    coef_t       coefs [MAX_NODES];
    node_cnt_t   sizes [NUM_GRAPHS];
    alpha_word_t word;
    int          n_nodes;
    void'($urandom(SEED));
    rst_n        = 1'b0;
    cfg_wr       = 1'b0;
    cfg_addr     = '0;
    cfg_num_node = '0;
    coef_wr      = 1'b0;
    coef         = '0;
    n_expected   = 0;
    n_written    = 0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;

    for (int g = 0; g < NUM_GRAPHS; g++) begin
      sizes[g] = node_cnt_t'($urandom_range(MAX_NODES, 1));
      // a few single-node subgraphs for the saturated case
      if (g == 2 || g == 17 || g == 31) begin
        sizes[g] = 4'd1;
      end
      // equal coefficients over a full-size subgraph
      if (g == EQUAL_GRAPH) begin
        sizes[g] = node_cnt_t'(MAX_NODES);
      end
      @(negedge clk);
      cfg_wr       = 1'b1;
      cfg_addr     = graph_idx_t'(g);
      cfg_num_node = sizes[g];
    end
    @(negedge clk);
    cfg_wr = 1'b0;

    for (int g = 0; g < NUM_GRAPHS; g++) begin
      n_nodes = int'(sizes[g]);
      for (int i = 0; i < n_nodes; i++) begin
        coefs[i] = coef_t'($urandom_range(MAX_COEF, 0));
        if (g == EQUAL_GRAPH && i > 0) begin
          coefs[i] = coefs[0];
        end
      end
      for (int i = 0; i < n_nodes; i++) begin
        word.alpha = ref_alpha(coefs, n_nodes, i);
        word.last  = (i == n_nodes - 1);
        exp_q.push_back(word);
      end
      n_expected = n_expected + n_nodes;
      for (int i = 0; i < n_nodes; i++) begin
        @(negedge clk);
        coef_wr = 1'b0;
        check_coef_full(coef_full, n_written - n_checked);
        while (coef_full || $urandom_range(3, 0) == 0) begin
          @(negedge clk);
          check_coef_full(coef_full, n_written - n_checked);
        end
        coef_wr   = 1'b1;
        coef      = coefs[i];
        n_written = n_written + 1;
      end
    end
    @(negedge clk);
    coef_wr = 1'b0;

    wait (n_checked == n_expected);
    // nothing may follow the last expected word
    repeat (DIV_LATENCY + 4) @(negedge clk);
    if (!out_empty || exp_q.size() != 0) begin
      abort_run("DUT produced more alpha words than were expected");
    end else begin
      $display("test passed");
      $finish;
    end
  end

  // enable in random runs, often dropped mid-subgraph
  initial begin
    sm_en = 1'b0;
    @(posedge rst_n);
    forever begin
      @(negedge clk);
      sm_en = 1'b1;
      repeat ($urandom_range(30, 1)) @(negedge clk);
      sm_en = 1'b0;
      repeat ($urandom_range(6, 1)) @(negedge clk);
    end
  end

  // ======================================================================
  // compare: pop on out_rd and check against the model
  // ======================================================================
  initial begin
    alpha_word_t want;
    int          pause;
    out_rd    = 1'b0;
    n_checked = 0;
    pause     = 0;
    @(posedge rst_n);
    forever begin
      @(negedge clk);
      out_rd = 1'b0;
      if (pause > 0) begin
        pause = pause - 1;
      end else if ($urandom_range(40, 0) == 0) begin
        // long pause so the output FIFO fills and the stall fires
        pause = int'($urandom_range(60, 20));
      end else if (!out_empty && $urandom_range(3, 0) != 0) begin
        if (exp_q.size() == 0) begin
          abort_run("DUT produced an alpha word that was never expected");
        end else begin
          want = exp_q.pop_front();
          check_alpha(out_word.alpha, want.alpha, n_checked);
          check_last(out_word.last, want.last, n_checked);
          n_checked = n_checked + 1;
          out_rd    = 1'b1;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("timeout after %0d cycles with %0d of %0d words checked",
                          cycle_cnt, n_checked, n_expected));
    end
  end

endmodule

// ==== gat_softmax.f ====
design/gat_softmax_pkg.sv
design/sync_fifo.sv
design/coef_ingress.sv
design/softmax_unit.sv
design/fxp_div_pipe.sv
design/alpha_egress.sv
design/gat_softmax_top.sv
verif/gat_softmax_tb.sv

// ==== Makefile ====
# all of these can be overridden on the command line
VERILATOR ?= verilator
TOP       ?= gat_softmax_tb
FILELIST  ?= gat_softmax.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= test failed
PASS_MSG  ?= test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation reported a failure"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
